// ==== tiny_core_pkg.sv ====
`default_nettype none

package tiny_core_pkg;

    // Operation codes in the top nibble of every instruction word
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_JMP  = 4'd6,
        OP_HALT = 4'd7
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_t;

    typedef logic [3:0] reg_addr_t;

    // Register form computes rd = rs1 op rs2
    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [15:0] unused;
    } r_format_t;

    // Immediate form with a sign-extended imm
    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic [19:0] imm;
    } i_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_t;

endpackage

`default_nettype wire

// ==== program_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_counter #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         available, // Request level from control
    input  wire  [31:0] in,        // New PC value
    output logic [31:0] pc,
    output logic        busy
);

    localparam logic [1:0] PC_IDLE        = 2'd0;
    localparam logic [1:0] PC_IN_PROGRESS = 2'd1;
    localparam logic [1:0] PC_DONE        = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= RESET_PC;
            busy  <= 1'b0;
            state <= PC_IDLE;
        end else begin
            case (state)
                PC_IDLE: begin
                    busy <= available; // Take the request
                    if (available) begin
                        state <= PC_IN_PROGRESS;
                    end
                end
                PC_IN_PROGRESS: begin
                    pc    <= in;
                    busy  <= 1'b0; // Drop busy once loaded
                    state <= PC_DONE;
                end
                PC_DONE: begin
                    // Hold until the request is withdrawn
                    if (!available) begin
                        state <= PC_IDLE;
                    end
                end
                default: begin
                    busy  <= 1'b0;
                    state <= PC_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== core_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_control (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        run,
    input  wire  tiny_core_pkg::instr_t instr,
    input  wire  [31:0]                pc,
    input  wire                        pc_busy,
    output logic                       pc_available,
    output logic [31:0]                pc_next,
    output tiny_core_pkg::reg_addr_t   rs1_addr,
    output tiny_core_pkg::reg_addr_t   rs2_addr,
    input  wire  [31:0]                rs1_data,
    output tiny_core_pkg::alu_op_t     alu_op,
    output logic                       use_imm,
    output logic [31:0]                imm,
    input  wire  [31:0]                alu_result,
    output logic                       rd_we,
    output tiny_core_pkg::reg_addr_t   rd_addr,
    output logic [31:0]                rd_data,
    output logic                       retire,
    output tiny_core_pkg::reg_addr_t   retire_rd,
    output logic [31:0]                retire_value,
    output logic                       halted
);
    import tiny_core_pkg::*;

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_FETCH     = 3'd1;
    localparam logic [2:0] S_EXECUTE   = 3'd2;
    localparam logic [2:0] S_WRITEBACK = 3'd3;
    localparam logic [2:0] S_PC_UPDATE = 3'd4;
    localparam logic [2:0] S_HALT      = 3'd5;

    logic [2:0]  state;
    logic        seen_busy; // Counter has acknowledged the request
    logic        is_halt;
    logic        wb_we;
    reg_addr_t   wb_rd;
    logic [31:0] wb_value;
    opcode_t     op;
    logic [31:0] pc_plus4;

    // Both formats share opcode and register fields
    assign op       = instr.r.opcode;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign imm      = {{12{instr.i.imm[19]}}, instr.i.imm};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        case (op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_ADDI: use_imm = 1'b1;
            OP_JMP:  use_imm = 1'b1;
            default: alu_op = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            pc_available <= 1'b0;
            seen_busy    <= 1'b0;
            is_halt      <= 1'b0;
            wb_we        <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (run) state <= S_FETCH;
                S_FETCH: state <= run ? S_EXECUTE : S_IDLE; // ROM read issued here
                S_EXECUTE: begin
                    state    <= S_WRITEBACK;
                    is_halt  <= (op == OP_HALT);
                    wb_we    <= 1'b0;
                    wb_rd    <= '0;
                    wb_value <= '0;
                    pc_next  <= pc_plus4;
                    case (op)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
                            wb_we    <= 1'b1;
                            wb_rd    <= instr.r.rd;
                            wb_value <= alu_result;
                        end
                        OP_JMP: begin
                            wb_we    <= 1'b1;
                            wb_rd    <= instr.r.rd;
                            wb_value <= pc_plus4;   // Link
                            pc_next  <= rs1_data + imm;
                        end
                        default: wb_we <= 1'b0;  // HALT and unused codes write nothing
                    endcase
                end
                S_WRITEBACK: begin
                    if (is_halt) begin
                        state <= S_HALT;
                    end else begin
                        state        <= S_PC_UPDATE;
                        pc_available <= 1'b1;
                    end
                end
                S_PC_UPDATE: begin
                    if (pc_available && pc_busy) seen_busy <= 1'b1;
                    if (pc_available && seen_busy && !pc_busy) pc_available <= 1'b0;
                    // Counter leaves done on this edge as well
                    if (!pc_available && seen_busy) begin
                        seen_busy <= 1'b0;
                        state     <= S_FETCH;
                    end
                end
                S_HALT: state <= S_HALT; // Only reset leaves
                default: state <= S_IDLE;
            endcase
        end
    end

    assign rd_we        = (state == S_WRITEBACK) && wb_we;
    assign rd_addr      = wb_rd;
    assign rd_data      = wb_value;
    assign retire       = (state == S_WRITEBACK);
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;
    assign halted       = (state == S_HALT);

endmodule

`default_nettype wire

// ==== instr_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_rom #(
    parameter int ROM_DEPTH = 64
) (
    input  wire                         clk,
    input  wire                         prog_we,
    input  wire [$clog2(ROM_DEPTH)-1:0] prog_addr,
    input  wire [31:0]                  prog_data,
    input  wire [$clog2(ROM_DEPTH)-1:0] rd_addr,
    output logic [31:0]                 rd_data
);

    logic [31:0] mem [ROM_DEPTH];

    // Load port for use while the core is stopped
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // One cycle read latency
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire                           clk,
    input  wire                           reset,
    input  wire tiny_core_pkg::reg_addr_t rs1_addr,
    input  wire tiny_core_pkg::reg_addr_t rs2_addr,
    output logic [31:0]                   rs1_data,
    output logic [31:0]                   rs2_data,
    input  wire                           we,
    input  wire tiny_core_pkg::reg_addr_t wr_addr,
    input  wire [31:0]                    wr_data
);

    logic [31:0] regs [16];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != 4'd0)) begin
            regs[wr_addr] <= wr_data; // r0 stays zero
        end
    end

    // Combinational read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire tiny_core_pkg::alu_op_t op,
    input  wire [31:0]                  a,
    input  wire [31:0]                  b,
    output logic [31:0]                 result
);
    import tiny_core_pkg::*;

    // All arithmetic wraps at 32 bits
    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== tiny_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tiny_core #(
    parameter int          ROM_DEPTH = 64,
    parameter logic [31:0] RESET_PC  = 32'd0
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         run,
    input  wire                         prog_we,
    input  wire [$clog2(ROM_DEPTH)-1:0] prog_addr,
    input  wire [31:0]                  prog_data,
    output logic [31:0]                 pc,
    output logic                        retire,
    output tiny_core_pkg::reg_addr_t    retire_rd,
    output logic [31:0]                 retire_value,
    output logic                        halted
);
    import tiny_core_pkg::*;

    localparam int ROM_AW = $clog2(ROM_DEPTH);

    instr_t      instr;
    logic        pc_available;
    logic        pc_busy;
    logic [31:0] pc_next;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    reg_addr_t   rd_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] rd_data;
    logic        rd_we;
    alu_op_t     alu_op;
    logic        use_imm;
    logic [31:0] imm;
    logic [31:0] alu_b;
    logic [31:0] alu_result;

    program_counter #(
        .RESET_PC (RESET_PC)
    ) program_counter_i (
        .clk       (clk),
        .reset     (reset),
        .available (pc_available),
        .in        (pc_next),
        .pc        (pc),
        .busy      (pc_busy)
    );

    core_control core_control_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .instr        (instr),
        .pc           (pc),
        .pc_busy      (pc_busy),
        .pc_available (pc_available),
        .pc_next      (pc_next),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .imm          (imm),
        .alu_result   (alu_result),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .retire       (retire),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .halted       (halted)
    );

    // Word index of the PC addresses the store
    instr_rom #(
        .ROM_DEPTH (ROM_DEPTH)
    ) instr_rom_i (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_addr   (pc[ROM_AW+1:2]),
        .rd_data   (instr)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .wr_addr  (rd_addr),
        .wr_data  (rd_data)
    );

    assign alu_b = use_imm ? imm : rs2_data; // Operand B select

    alu alu_i (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result)
    );

endmodule

`default_nettype wire

// ==== tiny_core_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module tiny_core_assertions (
    input wire        clk,
    input wire        reset,
    input wire        retire,
    input wire        pc_available,
    input wire        pc_busy,
    input wire [31:0] pc
);

    int unsigned fail_count = 0; // Assertion failures so far

    // One retire pulse per instruction
    assert property (@(posedge clk) disable iff (reset) retire |=> !retire)
        else begin
            fail_count++;
            $error("retire high on two consecutive cycles");
        end

    // Counter takes a request only while the level is up
    assert property (@(posedge clk) disable iff (reset)
        $rose(pc_busy) |-> (pc_available && $past(pc_available)))
        else begin
            fail_count++;
            $error("pc_busy rose without pc_available");
        end

    // PC loads one cycle after the counter went busy
    assert property (@(posedge clk) disable iff (reset) !$stable(pc) |-> $past(pc_busy))
        else begin
            fail_count++;
            $error("pc changed without a preceding busy cycle");
        end

    assert property (@(posedge clk) reset |=> !pc_available)
        else begin
            fail_count++;
            $error("pc_available high after reset");
        end

endmodule

// Control block sees both sides of the PC exchange at its ports
bind core_control tiny_core_assertions tiny_core_assertions_i (
    .clk          (clk),
    .reset        (reset),
    .retire       (retire),
    .pc_available (pc_available),
    .pc_busy      (pc_busy),
    .pc           (pc)
);

`default_nettype wire

// ==== tiny_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tiny_core_tb;
    import tiny_core_pkg::*;

    localparam int          ROM_DEPTH      = 64;
    localparam int          ROM_AW         = $clog2(ROM_DEPTH);
    localparam logic [31:0] RESET_PC       = 32'd0;
    localparam int          PROG_LEN       = 25;
    localparam int          MAX_STEPS      = 64;
    localparam int          RETIRE_TIMEOUT = 40;
    localparam int          QUIET_CYCLES   = 60;

    logic              clk;
    logic              reset;
    logic              run;
    logic              prog_we;
    logic [ROM_AW-1:0] prog_addr;
    logic [31:0]       prog_data;
    logic [31:0]       pc;
    logic              retire;
    reg_addr_t         retire_rd;
    logic [31:0]       retire_value;
    logic              halted;

    logic [31:0] lcg_state = 32'h0de8_3d2a;
    instr_t      program_tbl [PROG_LEN];
    logic [31:0] exp_pc      [MAX_STEPS]; // Expected values per retire in order
    reg_addr_t   exp_rd      [MAX_STEPS];
    logic [31:0] exp_value   [MAX_STEPS];
    logic        exp_halt    [MAX_STEPS];
    int          n_steps;

    tiny_core #(
        .ROM_DEPTH (ROM_DEPTH),
        .RESET_PC  (RESET_PC)
    ) tiny_core_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .pc           (pc),
        .retire       (retire),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [19:0] rnd_imm();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:12]; // Upper bits are the better ones
    endfunction

    function automatic instr_t make_r(opcode_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        instr_t w;
        w.r.opcode = op;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        w.r.unused = '0;
        return w;
    endfunction

    function automatic instr_t make_i(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                      logic [19:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: at %0t ns, %s = %h, expected %h", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_reg(input string name, input reg_addr_t got,
                               input reg_addr_t expected);
        if (got !== expected) begin
            $display("error: at %0t ns, %s = %h, expected %h", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("error: at %0t ns, %s = %b, expected %b", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic build_program();
        program_tbl[0]  = make_i(OP_ADDI, 4'd1, 4'd0, rnd_imm());
        program_tbl[1]  = make_i(OP_ADDI, 4'd2, 4'd0, rnd_imm());
        program_tbl[2]  = make_i(OP_ADDI, 4'd3, 4'd0, rnd_imm() | 20'h80000); // Negative
        program_tbl[3]  = make_i(OP_ADDI, 4'd4, 4'd0, rnd_imm() & 20'h7ffff);
        program_tbl[4]  = make_r(OP_ADD, 4'd5, 4'd1, 4'd2);
        program_tbl[5]  = make_r(OP_SUB, 4'd6, 4'd3, 4'd4);
        program_tbl[6]  = make_r(OP_AND, 4'd7, 4'd1, 4'd3);
        program_tbl[7]  = make_r(OP_OR, 4'd8, 4'd2, 4'd4);
        program_tbl[8]  = make_r(OP_XOR, 4'd9, 4'd5, 4'd6);
        program_tbl[9]  = make_r(OP_ADD, 4'd10, 4'd3, 4'd3); // Wraps past 2**32
        program_tbl[10] = make_i(OP_ADDI, 4'd11, 4'd5, rnd_imm() | 20'h80000);
        program_tbl[11] = make_i(OP_ADDI, 4'd12, 4'd6, rnd_imm() & 20'h7ffff);
        program_tbl[12] = make_r(OP_ADD, 4'd0, 4'd1, 4'd2);   // Discarded write
        program_tbl[13] = make_r(OP_OR, 4'd13, 4'd0, 4'd4);
        program_tbl[14] = make_i(OP_JMP, 4'd14, 4'd0, 20'd72); // To word 18
        program_tbl[15] = make_r(OP_HALT, 4'd0, 4'd0, 4'd0);
        program_tbl[16] = make_r(OP_HALT, 4'd0, 4'd0, 4'd0);
        program_tbl[17] = make_r(OP_HALT, 4'd0, 4'd0, 4'd0);
        program_tbl[18] = make_i(OP_ADDI, 4'd15, 4'd14, rnd_imm() & 20'h7ffff);
        program_tbl[19] = make_i(OP_ADDI, 4'd6, 4'd0, 20'd64);
        program_tbl[20] = make_i(OP_JMP, 4'd7, 4'd6, 20'd28);  // Target 64 + 28 is word 23
        program_tbl[21] = make_r(OP_HALT, 4'd0, 4'd0, 4'd0);
        program_tbl[22] = make_r(OP_HALT, 4'd0, 4'd0, 4'd0);
        program_tbl[23] = make_r(OP_SUB, 4'd1, 4'd15, 4'd7);
        program_tbl[24] = make_r(OP_HALT, 4'd0, 4'd0, 4'd0);
    endtask

    // Instruction-level model with one entry per expected retire
    task automatic run_model();
        logic [31:0] regs [16];
        logic [31:0] mpc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm32;
        logic [31:0] result;
        instr_t      ins;
        int          idx;
        logic        halt_seen;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        mpc       = RESET_PC;
        n_steps   = 0;
        halt_seen = 1'b0;
        while (!halt_seen && n_steps < MAX_STEPS && (mpc >> 2) < PROG_LEN) begin
            idx       = int'(mpc >> 2);
            ins       = program_tbl[idx];
            a         = regs[ins.r.rs1];
            b         = regs[ins.r.rs2];
            imm32     = {{12{ins.i.imm[19]}}, ins.i.imm};
            halt_seen = (ins.r.opcode == OP_HALT);
            case (ins.r.opcode)
                OP_ADD:  result = a + b;
                OP_SUB:  result = a - b;
                OP_AND:  result = a & b;
                OP_OR:   result = a | b;
                OP_XOR:  result = a ^ b;
                OP_ADDI: result = a + imm32;
                OP_JMP:  result = mpc + 32'd4; // Link
                default: result = '0;
            endcase
            exp_pc[n_steps]    = mpc;
            exp_rd[n_steps]    = halt_seen ? 4'd0 : ins.r.rd;
            exp_value[n_steps] = result;
            exp_halt[n_steps]  = halt_seen;
            n_steps++;
            if (!halt_seen && ins.r.rd != 4'd0) begin
                regs[ins.r.rd] = result;
            end
            mpc = (ins.r.opcode == OP_JMP) ? a + imm32 : mpc + 32'd4;
        end
        if (!halt_seen) begin
            $display("reference model left the program without reaching a HALT");
            stop_with_failure();
        end
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (retire !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (retire !== 1'b1) begin
            $display("timeout, no retire pulse within %0d cycles", RETIRE_TIMEOUT);
            stop_with_failure();
        end
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (halted !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (halted !== 1'b1) begin
            $display("timeout, halted did not rise within %0d cycles", RETIRE_TIMEOUT);
            stop_with_failure();
        end
    endtask

    always @(negedge clk) begin
        if (tiny_core_i.core_control_i.tiny_core_assertions_i.fail_count != 0) begin
            $display("a concurrent assertion on the core failed");
            stop_with_failure();
        end
    end

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        compare_word("pc", pc, RESET_PC);
        compare_bit("retire", retire, 1'b0);
        compare_bit("halted", halted, 1'b0);

        // Load while the core is stopped
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = ROM_AW'(i);
            prog_data = program_tbl[i];
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
        run     = 1'b1;

        for (int k = 0; k < n_steps; k++) begin
            wait_retire();
            compare_word("pc", pc, exp_pc[k]);
            compare_reg("retire_rd", retire_rd, exp_rd[k]);
            if (!exp_halt[k]) begin
                compare_word("retire_value", retire_value, exp_value[k]);
                compare_bit("halted", halted, 1'b0);
            end
        end

        wait_halted();
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(negedge clk);
            if (retire !== 1'b0) begin
                $display("retire pulse seen after the core halted");
                stop_with_failure();
            end else begin
                compare_bit("halted", halted, 1'b1);
            end
        end

        if (tiny_core_i.core_control_i.tiny_core_assertions_i.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== tiny_core.f ====
tiny_core_pkg.sv
program_counter.sv
core_control.sv
instr_rom.sv
register_file.sv
alu.sv
tiny_core.sv
tiny_core_assertions.sv
tiny_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build from the file list, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tiny_core_tb -f tiny_core.f -o tiny_core_sim &&
    ./obj_dir/tiny_core_sim +verilator+error+limit+10 2>&1 | tee sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
